/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module tb_child_manager -o vsim

run: compile
	./obj_dir/vsim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
+incdir+design
design/cm_task_pkg.sv
design/cm_track_pkg.sv
design/enq_arbiter.sv
design/child_table.sv
design/abort_walker.sv
design/child_manager.sv
testbench/tb_child_manager.sv

/* design/abort_walker.sv */
`default_nettype none

module abort_walker (
   input  wire logic                        clk,
   input  wire logic                        rstn,
   input  wire logic                        cq_abort_valid,
   input  wire cm_task_pkg::cq_slot_t       cq_abort_slot,
   input  wire cm_task_pkg::child_id_t      cq_abort_count,
   output logic                             cq_abort_ready,
   output cm_task_pkg::child_ref_t          rd_ref,
   input  wire cm_track_pkg::child_entry_t  rd_entry,
   output logic                             abort_child_valid,
   output cm_task_pkg::child_loc_t          abort_child_loc,
   output cm_task_pkg::child_ref_t          abort_child_ref,
   input  wire logic                        abort_child_ready,
   input  wire logic                        abort_resp_valid,
   output logic                             fin_write,
   output cm_task_pkg::child_ref_t          fin_ref,
   output logic                             abort_ack_valid,
   output cm_task_pkg::cq_slot_t            abort_ack_slot,
   input  wire logic                        abort_ack_ready
);
   import cm_task_pkg::*;
   import cm_track_pkg::*;

   walk_state_e state_q;
   cq_slot_t    slot_q;
   child_id_t   count_q;
   child_id_t   cur_q;
   child_id_t   next_child;
   child_id_t   outstanding_q;
   logic        advance;
   logic        child_sent;

   assign cq_abort_ready = (state_q == IDLE);
   assign rd_ref         = '{cq_slot: slot_q, child_id: cur_q};
   assign next_child     = cur_q + 1'b1;

   // Decide what to do with the child under the pointer
   always_comb begin
      advance           = 1'b0;
      abort_child_valid = 1'b0;
      fin_write         = 1'b0;
      if (state_q == WALK) begin
         unique case (rd_entry.state)
            ACKED: begin
               abort_child_valid = 1'b1;
               advance           = abort_child_ready;
               fin_write         = abort_child_ready;
            end
            // Still in flight, wait for the task buffer response
            SENT:    advance = 1'b0;
            default: advance = 1'b1;
         endcase
      end
   end

   assign child_sent      = abort_child_valid && abort_child_ready;
   assign abort_child_loc = rd_entry.loc;
   assign abort_child_ref = rd_ref;
   assign fin_ref         = rd_ref;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q <= IDLE;
         cur_q   <= '0;
      end else begin
         unique case (state_q)
            IDLE: begin
               if (cq_abort_valid) begin
                  cur_q   <= '0;
                  // Zero children passes through DRAIN straight to ACK
                  state_q <= (cq_abort_count == '0) ? DRAIN : WALK;
               end
            end
            WALK: begin
               if (advance) begin
                  cur_q <= next_child;
                  if (next_child == count_q) begin
                     state_q <= DRAIN;
                  end
               end
            end
            DRAIN: begin
               if (outstanding_q == '0) begin
                  state_q <= ACK;
               end
            end
            ACK: begin
               if (abort_ack_ready) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (cq_abort_valid && cq_abort_ready) begin
         slot_q  <= cq_abort_slot;
         count_q <= cq_abort_count;
      end
   end

   // Tile responses still owed for this walk
   always_ff @(posedge clk) begin
      if (!rstn) begin
         outstanding_q <= '0;
      end else if (child_sent && !abort_resp_valid) begin
         outstanding_q <= outstanding_q + 1'b1;
      end else if (abort_resp_valid && !child_sent) begin
         outstanding_q <= outstanding_q - 1'b1;
      end
   end

   assign abort_ack_valid = (state_q == ACK);
   assign abort_ack_slot  = slot_q;

endmodule

`default_nettype wire

/* design/child_manager.sv */
`default_nettype none

`include "cm_settings.svh"

module child_manager (
   input  wire logic                                    clk,
   input  wire logic                                    rstn,
   input  wire logic                   [`CM_N_SI-1:0] s_wvalid,
   output logic                        [`CM_N_SI-1:0] s_wready,
   input  wire cm_task_pkg::task_t      [`CM_N_SI-1:0] s_wdata,
   input  wire logic                   [`CM_N_SI-1:0] s_enq_untied,
   input  wire cm_task_pkg::child_ref_t [`CM_N_SI-1:0] s_ref,
   output logic                                         task_enq_valid,
   input  wire logic                                    task_enq_ready,
   output cm_task_pkg::task_t                           task_enq_data,
   output logic                                         task_enq_tied,
   output cm_task_pkg::child_ref_t                      task_enq_ref,
   input  wire logic                                    task_enq_only_untied,
   input  wire logic                                    task_resp_valid,
   output logic                                         task_resp_ready,
   input  wire cm_task_pkg::child_ref_t                 task_resp_ref,
   input  wire cm_task_pkg::child_loc_t                 task_resp_loc,
   input  wire logic                                    cq_abort_valid,
   output logic                                         cq_abort_ready,
   input  wire cm_task_pkg::cq_slot_t                   cq_abort_slot,
   input  wire cm_task_pkg::child_id_t                  cq_abort_count,
   output logic                                         abort_child_valid,
   input  wire logic                                    abort_child_ready,
   output cm_task_pkg::child_loc_t                      abort_child_loc,
   output cm_task_pkg::child_ref_t                      abort_child_ref,
   input  wire logic                                    abort_resp_valid,
   output logic                                         abort_resp_ready,
   output logic                                         abort_ack_valid,
   input  wire logic                                    abort_ack_ready,
   output cm_task_pkg::cq_slot_t                        abort_ack_slot
);
   import cm_task_pkg::*;
   import cm_track_pkg::*;

   logic         enq_write;
   child_ref_t   enq_write_ref;
   logic         enq_write_tied;
   child_ref_t   rd_ref;
   child_entry_t rd_entry;
   logic         fin_write;
   child_ref_t   fin_ref;

   // Every response is taken as it arrives
   assign task_resp_ready  = 1'b1;
   assign abort_resp_ready = 1'b1;

   enq_arbiter u_enq_arbiter (
      .clk                  (clk),
      .rstn                 (rstn),
      .s_wvalid             (s_wvalid),
      .s_wdata              (s_wdata),
      .s_enq_untied         (s_enq_untied),
      .s_ref                (s_ref),
      .s_wready             (s_wready),
      .task_enq_only_untied (task_enq_only_untied),
      .task_enq_ready       (task_enq_ready),
      .task_enq_valid       (task_enq_valid),
      .task_enq_data        (task_enq_data),
      .task_enq_tied        (task_enq_tied),
      .task_enq_ref         (task_enq_ref),
      .enq_write            (enq_write),
      .enq_write_ref        (enq_write_ref),
      .enq_write_tied       (enq_write_tied)
   );

   child_table u_child_table (
      .clk             (clk),
      .rstn            (rstn),
      .enq_write       (enq_write),
      .enq_write_ref   (enq_write_ref),
      .enq_write_tied  (enq_write_tied),
      .task_resp_valid (task_resp_valid),
      .task_resp_ref   (task_resp_ref),
      .task_resp_loc   (task_resp_loc),
      .fin_write       (fin_write),
      .fin_ref         (fin_ref),
      .rd_ref          (rd_ref),
      .rd_entry        (rd_entry)
   );

   abort_walker u_abort_walker (
      .clk               (clk),
      .rstn              (rstn),
      .cq_abort_valid    (cq_abort_valid),
      .cq_abort_slot     (cq_abort_slot),
      .cq_abort_count    (cq_abort_count),
      .cq_abort_ready    (cq_abort_ready),
      .rd_ref            (rd_ref),
      .rd_entry          (rd_entry),
      .abort_child_valid (abort_child_valid),
      .abort_child_loc   (abort_child_loc),
      .abort_child_ref   (abort_child_ref),
      .abort_child_ready (abort_child_ready),
      .abort_resp_valid  (abort_resp_valid),
      .fin_write         (fin_write),
      .fin_ref           (fin_ref),
      .abort_ack_valid   (abort_ack_valid),
      .abort_ack_slot    (abort_ack_slot),
      .abort_ack_ready   (abort_ack_ready)
   );

endmodule

`default_nettype wire

/* design/child_table.sv */
`default_nettype none

`include "cm_settings.svh"

module child_table (
   input  wire logic                    clk,
   input  wire logic                    rstn,
   input  wire logic                    enq_write,
   input  wire cm_task_pkg::child_ref_t enq_write_ref,
   input  wire logic                    enq_write_tied,
   input  wire logic                    task_resp_valid,
   input  wire cm_task_pkg::child_ref_t task_resp_ref,
   input  wire cm_task_pkg::child_loc_t task_resp_loc,
   input  wire logic                    fin_write,
   input  wire cm_task_pkg::child_ref_t fin_ref,
   input  wire cm_task_pkg::child_ref_t rd_ref,
   output cm_track_pkg::child_entry_t   rd_entry
);
   import cm_task_pkg::*;
   import cm_track_pkg::*;

   localparam int IDX_W     = `CM_LOG_CQ_SLOTS + `CM_LOG_CHILDREN;
   localparam int N_ENTRIES = 1 << IDX_W;

   child_state_e state_q [N_ENTRIES];
   child_loc_t   loc_q   [N_ENTRIES];

   // Entry index is the parent slot followed by the child index
   function automatic logic [IDX_W-1:0] entry_idx(input child_ref_t r);
      return {r.cq_slot, r.child_id[`CM_LOG_CHILDREN-1:0]};
   endfunction

   // The three writers never hit the same entry in one cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < N_ENTRIES; i++) begin
            state_q[i] <= EMPTY;
         end
      end else begin
         // Untied children get no response, so they are not tracked
         if (enq_write && enq_write_tied) begin
            state_q[entry_idx(enq_write_ref)] <= SENT;
         end
         if (task_resp_valid) begin
            state_q[entry_idx(task_resp_ref)] <= ACKED;
         end
         if (fin_write) begin
            state_q[entry_idx(fin_ref)] <= FINALIZED;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (task_resp_valid) begin
         loc_q[entry_idx(task_resp_ref)] <= task_resp_loc;
      end
   end

   always_comb begin
      rd_entry.state = state_q[entry_idx(rd_ref)];
      rd_entry.loc   = loc_q[entry_idx(rd_ref)];
   end

endmodule

`default_nettype wire

/* design/cm_settings.svh */
`ifndef CM_SETTINGS_SVH
`define CM_SETTINGS_SVH

// Number of cores offering child tasks
`define CM_N_SI 4

// Parent slots in the commit queue, as log2
`define CM_LOG_CQ_SLOTS 2

// Children tracked per parent, as log2
`define CM_LOG_CHILDREN 2

// Location and task field widths
`define CM_TILE_W 2
`define CM_TQ_SLOT_W 4
`define CM_EPOCH_W 8
`define CM_TS_W 16

`endif

/* design/cm_task_pkg.sv */
`default_nettype none

`include "cm_settings.svh"

package cm_task_pkg;

   typedef logic [`CM_LOG_CQ_SLOTS-1:0] cq_slot_t;
   // One extra bit so a full child count fits
   typedef logic [`CM_LOG_CHILDREN:0]   child_id_t;

   typedef logic [`CM_TILE_W-1:0]       tile_id_t;
   typedef logic [`CM_TQ_SLOT_W-1:0]    tq_slot_t;
   typedef logic [`CM_EPOCH_W-1:0]      epoch_t;
   typedef logic [`CM_TS_W-1:0]         ts_t;

   typedef struct packed {
      ts_t         ts;
      logic [15:0] payload;
   } task_t;

   // Where an acknowledged child lives
   typedef struct packed {
      tile_id_t tile;
      tq_slot_t tq_slot;
      epoch_t   epoch;
   } child_loc_t;

   typedef struct packed {
      cq_slot_t  cq_slot;
      child_id_t child_id;
   } child_ref_t;

endpackage

`default_nettype wire

/* design/cm_track_pkg.sv */
`default_nettype none

package cm_track_pkg;

   // Life of one child entry
   typedef enum logic [1:0] {
      EMPTY,
      SENT,
      ACKED,
      FINALIZED
   } child_state_e;

   // Abort walk
   typedef enum logic [1:0] {
      IDLE,
      WALK,
      DRAIN,
      ACK
   } walk_state_e;

   typedef struct packed {
      child_state_e            state;
      cm_task_pkg::child_loc_t loc;
   } child_entry_t;

endpackage

`default_nettype wire

/* design/enq_arbiter.sv */
`default_nettype none

`include "cm_settings.svh"

module enq_arbiter (
   input  wire logic                                    clk,
   input  wire logic                                    rstn,
   input  wire logic                   [`CM_N_SI-1:0] s_wvalid,
   input  wire cm_task_pkg::task_t      [`CM_N_SI-1:0] s_wdata,
   input  wire logic                   [`CM_N_SI-1:0] s_enq_untied,
   input  wire cm_task_pkg::child_ref_t [`CM_N_SI-1:0] s_ref,
   output logic                        [`CM_N_SI-1:0] s_wready,
   input  wire logic                                    task_enq_only_untied,
   input  wire logic                                    task_enq_ready,
   output logic                                         task_enq_valid,
   output cm_task_pkg::task_t                           task_enq_data,
   output logic                                         task_enq_tied,
   output cm_task_pkg::child_ref_t                      task_enq_ref,
   output logic                                         enq_write,
   output cm_task_pkg::child_ref_t                      enq_write_ref,
   output logic                                         enq_write_tied
);
   import cm_task_pkg::*;

   localparam int SEL_W = (`CM_N_SI > 1) ? $clog2(`CM_N_SI) : 1;

   logic [`CM_N_SI-1:0] untied_req;
   logic [SEL_W-1:0]    sel_untied;
   logic [SEL_W-1:0]    sel_any;
   logic [SEL_W-1:0]    sel;
   logic                any_untied;
   logic                any_req;
   logic                can_load;
   logic                accept;

   assign untied_req = s_wvalid & s_enq_untied;

   // Lowest index wins; scanning downward leaves the lowest hit last
   always_comb begin
      sel_untied = '0;
      sel_any    = '0;
      any_untied = 1'b0;
      any_req    = 1'b0;
      for (int i = `CM_N_SI - 1; i >= 0; i--) begin
         if (untied_req[i]) begin
            sel_untied = SEL_W'(i);
            any_untied = 1'b1;
         end
         if (s_wvalid[i]) begin
            sel_any = SEL_W'(i);
            any_req = 1'b1;
         end
      end
   end

   // Output register is free when empty or handing over this cycle
   assign can_load = !task_enq_valid || task_enq_ready;
   assign sel      = any_untied ? sel_untied : sel_any;
   assign accept   = can_load && (any_untied || (any_req && !task_enq_only_untied));

   always_comb begin
      s_wready      = '0;
      s_wready[sel] = accept;
   end

   // Table sees the acceptance in the same cycle
   assign enq_write      = accept;
   assign enq_write_ref  = s_ref[sel];
   assign enq_write_tied = !s_enq_untied[sel];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_enq_valid <= 1'b0;
      end else if (accept) begin
         task_enq_valid <= 1'b1;
      end else if (task_enq_ready) begin
         task_enq_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         task_enq_data <= s_wdata[sel];
         task_enq_tied <= !s_enq_untied[sel];
         task_enq_ref  <= s_ref[sel];
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_child_manager.sv */
`default_nettype none

`include "cm_settings.svh"

module tb_child_manager;
   import cm_task_pkg::*;
   import cm_track_pkg::*;

   localparam int N = `CM_N_SI;

   logic clk;
   logic rstn;
   logic [N-1:0] s_wvalid;
   logic [N-1:0] s_wready;
   task_t [N-1:0] s_wdata;
   logic [N-1:0] s_enq_untied;
   child_ref_t [N-1:0] s_ref;
   logic task_enq_valid;
   logic task_enq_ready;
   task_t task_enq_data;
   logic task_enq_tied;
   child_ref_t task_enq_ref;
   logic task_enq_only_untied;
   logic task_resp_valid;
   logic task_resp_ready;
   child_ref_t task_resp_ref;
   child_loc_t task_resp_loc;
   logic cq_abort_valid;
   logic cq_abort_ready;
   cq_slot_t cq_abort_slot;
   child_id_t cq_abort_count;
   logic abort_child_valid;
   logic abort_child_ready = 1'b0;
   child_loc_t abort_child_loc;
   child_ref_t abort_child_ref;
   logic abort_resp_valid = 1'b0;
   logic abort_resp_ready;
   logic abort_ack_valid;
   logic abort_ack_ready;
   cq_slot_t abort_ack_slot;

   integer seed;
   logic [31:0] rnd;
   logic [31:0] tile_rnd;
   int resp_owed;

   // Reference model of the children table and of the current walk
   child_state_e model_state [16];
   child_loc_t model_loc [16];
   cq_slot_t walk_slot;
   child_id_t walk_count;
   child_id_t walk_min;
   logic walk_busy;

   logic [N-1:0] exp_wready;
   task_t acc_data;
   logic acc_untied;
   child_ref_t acc_ref;
   logic req_ok;
   logic ack_ok;

   child_manager dut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [3:0] entry_of(input child_ref_t r);
      return {r.cq_slot, r.child_id[1:0]};
   endfunction

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at time %0t: %s", $time, msg);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic report_timeout(input string msg);
      $display("Timed out at time %0t while waiting: %s", $time, msg);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   // Untied first, then lowest index, and only when the output can load
   always_comb begin
      int pick;
      pick = -1;
      exp_wready = '0;
      for (int i = 0; i < N; i++) begin
         if (pick < 0 && s_wvalid[i] && s_enq_untied[i]) pick = i;
      end
      for (int i = 0; i < N; i++) begin
         if (pick < 0 && !task_enq_only_untied && s_wvalid[i]) pick = i;
      end
      if (pick >= 0 && (!task_enq_valid || task_enq_ready)) exp_wready[pick] = 1'b1;
   end

   always_comb begin
      acc_data = '0;
      acc_untied = 1'b0;
      acc_ref = '0;
      for (int i = 0; i < N; i++) begin
         if (exp_wready[i]) begin
            acc_data = s_wdata[i];
            acc_untied = s_enq_untied[i];
            acc_ref = s_ref[i];
         end
      end
   end

   // A request must be the next live child, with its stored location
   always_comb begin
      child_state_e st;
      req_ok = (abort_child_ref.cq_slot == walk_slot) &&
               (abort_child_ref.child_id < walk_count) &&
               (model_state[entry_of(abort_child_ref)] == ACKED) &&
               (model_loc[entry_of(abort_child_ref)] == abort_child_loc);
      ack_ok = (abort_ack_slot == walk_slot) && (resp_owed == 0);
      for (int j = 0; j < 4; j++) begin
         st = model_state[{walk_slot, 2'(j)}];
         if (j >= int'(walk_min) && (st == SENT || st == ACKED)) begin
            if (j < int'(abort_child_ref.child_id)) req_ok = 1'b0;
            if (j < int'(walk_count)) ack_ok = 1'b0;
         end
      end
   end

   always @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 16; i++) model_state[i] <= EMPTY;
         walk_slot <= '0;
         walk_count <= '0;
         walk_min <= '0;
         walk_busy <= 1'b0;
      end else begin
         for (int i = 0; i < N; i++) begin
            if (s_wvalid[i] && exp_wready[i] && !s_enq_untied[i])
               model_state[entry_of(s_ref[i])] <= SENT;
         end
         if (task_resp_valid) begin
            model_state[entry_of(task_resp_ref)] <= ACKED;
            model_loc[entry_of(task_resp_ref)] <= task_resp_loc;
         end
         if (abort_child_valid && abort_child_ready) begin
            model_state[entry_of(abort_child_ref)] <= FINALIZED;
            walk_min <= abort_child_ref.child_id + 1'b1;
         end
         if (abort_ack_valid && abort_ack_ready) begin
            walk_busy <= 1'b0;
         end
         if (cq_abort_valid && cq_abort_ready) begin
            walk_slot <= cq_abort_slot;
            walk_count <= cq_abort_count;
            walk_min <= '0;
            walk_busy <= 1'b1;
         end
      end
   end

   // Tile side accepts aborts at random and answers each one later
   always @(posedge clk) begin
      int owed_next;
      if (!rstn) begin
         resp_owed <= 0;
         abort_resp_valid <= 1'b0;
         abort_child_ready <= 1'b0;
      end else begin
         owed_next = resp_owed + int'(abort_child_valid && abort_child_ready)
                     - int'(abort_resp_valid);
         tile_rnd = $random(seed);
         resp_owed <= owed_next;
         abort_resp_valid <= (owed_next != 0) && tile_rnd[0];
         abort_child_ready <= tile_rnd[1] | tile_rnd[2];
      end
   end

   assert property (@(posedge clk) $rose(rstn) |-> !task_enq_valid && !abort_child_valid
                    && !abort_ack_valid && cq_abort_ready)
      else report_mismatch("outputs not idle after reset");
   assert property (@(posedge clk) disable iff (!rstn) $onehot0(s_wready))
      else report_mismatch("more than one s_wready");
   assert property (@(posedge clk) disable iff (!rstn) s_wready == exp_wready)
      else report_mismatch("wrong core accepted");
   assert property (@(posedge clk) disable iff (!rstn) (|s_wready) |=> task_enq_valid
                    && task_enq_data == $past(acc_data) && task_enq_ref == $past(acc_ref)
                    && task_enq_tied == !$past(acc_untied))
      else report_mismatch("task_enq output does not match accepted task");
   assert property (@(posedge clk) disable iff (!rstn) (task_enq_valid && !task_enq_ready)
                    |=> task_enq_valid && $stable(task_enq_data) && $stable(task_enq_ref))
      else report_mismatch("task_enq output changed under back-pressure");
   assert property (@(posedge clk) disable iff (!rstn) abort_child_valid |-> req_ok)
      else report_mismatch("abort_child request out of order or wrong location");
   assert property (@(posedge clk) disable iff (!rstn) abort_ack_valid |-> ack_ok)
      else report_mismatch("abort ack early or with wrong slot");
   assert property (@(posedge clk) disable iff (!rstn) cq_abort_ready == !walk_busy)
      else report_mismatch("cq_abort_ready wrong for the walk in progress");
   assert property (@(posedge clk) disable iff (!rstn) task_resp_ready && abort_resp_ready)
      else report_mismatch("response ready not held high");

   task automatic enqueue_child(input int core, input child_ref_t r, input logic untied);
      int t;
      t = 0;
      @(posedge clk);
      s_wvalid[core] <= 1'b1;
      s_enq_untied[core] <= untied;
      s_ref[core] <= r;
      s_wdata[core] <= $random(seed);
      do begin
         @(posedge clk);
         t++;
         if (t > 50) report_timeout("child task never accepted");
      end while (!s_wready[core]);
      s_wvalid[core] <= 1'b0;
   endtask

   task automatic respond(input child_ref_t r);
      @(posedge clk);
      task_resp_valid <= 1'b1;
      task_resp_ref <= r;
      task_resp_loc <= child_loc_t'($random(seed));
      @(posedge clk);
      task_resp_valid <= 1'b0;
   endtask

   task automatic start_abort(input cq_slot_t slot, input child_id_t count);
      int t;
      t = 0;
      do begin
         @(posedge clk);
         t++;
         if (t > 200) report_timeout("cq_abort_ready never came back");
      end while (!cq_abort_ready);
      cq_abort_valid <= 1'b1;
      cq_abort_slot <= slot;
      cq_abort_count <= count;
      @(posedge clk);
      cq_abort_valid <= 1'b0;
   endtask

   task automatic wait_ack();
      int t;
      t = 0;
      do begin
         @(posedge clk);
         t++;
         if (t > 300) report_timeout("abort never acknowledged");
      end while (!(abort_ack_valid && abort_ack_ready));
   endtask

   initial begin
      int t;
      seed = 32'hbc7d_726e;
      rstn = 1'b0;
      s_wvalid = '0;
      s_wdata = '0;
      s_enq_untied = '0;
      s_ref = '0;
      task_enq_ready = 1'b0;
      task_enq_only_untied = 1'b0;
      task_resp_valid = 1'b0;
      task_resp_ref = '0;
      task_resp_loc = '0;
      cq_abort_valid = 1'b0;
      cq_abort_slot = '0;
      cq_abort_count = '0;
      abort_ack_ready = 1'b1;
      repeat (3) @(posedge clk);
      rstn <= 1'b1;

      // Random arbitration traffic, kept to parent slots 2 and 3
      repeat (300) begin
         @(posedge clk);
         for (int i = 0; i < N; i++) begin
            if (!s_wvalid[i] || s_wready[i]) begin
               rnd = $random(seed);
               s_wvalid[i] <= rnd[0] | rnd[1];
               s_enq_untied[i] <= rnd[2];
               s_ref[i] <= '{cq_slot: {1'b1, rnd[3]}, child_id: {1'b0, rnd[5:4]}};
               s_wdata[i] <= $random(seed);
            end
         end
         rnd = $random(seed);
         task_enq_ready <= rnd[0] | rnd[1];
         task_enq_only_untied <= (rnd[4:2] == 3'd0);
      end
      task_enq_only_untied <= 1'b0;
      task_enq_ready <= 1'b1;
      t = 0;
      do begin
         @(posedge clk);
         t++;
         if (t > 100) report_timeout("cores never drained");
         for (int i = 0; i < N; i++) begin
            if (s_wready[i]) s_wvalid[i] <= 1'b0;
         end
      end while (|s_wvalid);

      // Slot 0 with acked, untied and never-sent children
      enqueue_child(1, '{cq_slot: 2'd0, child_id: 3'd0}, 1'b0);
      enqueue_child(2, '{cq_slot: 2'd0, child_id: 3'd1}, 1'b1);
      enqueue_child(0, '{cq_slot: 2'd0, child_id: 3'd2}, 1'b0);
      respond('{cq_slot: 2'd0, child_id: 3'd2});
      respond('{cq_slot: 2'd0, child_id: 3'd0});
      start_abort(2'd0, 3'd4);
      wait_ack();

      // Slot 1 with children still in flight during the walk
      enqueue_child(3, '{cq_slot: 2'd1, child_id: 3'd0}, 1'b0);
      enqueue_child(0, '{cq_slot: 2'd1, child_id: 3'd1}, 1'b0);
      enqueue_child(2, '{cq_slot: 2'd1, child_id: 3'd2}, 1'b0);
      respond('{cq_slot: 2'd1, child_id: 3'd0});
      start_abort(2'd1, 3'd4);
      repeat (8) @(posedge clk);
      respond('{cq_slot: 2'd1, child_id: 3'd1});
      repeat (5) @(posedge clk);
      respond('{cq_slot: 2'd1, child_id: 3'd2});
      wait_ack();

      // Finalized children are not aborted twice, and an empty count still acks
      start_abort(2'd1, 3'd4);
      wait_ack();
      start_abort(2'd2, 3'd0);
      wait_ack();

      repeat (5) @(posedge clk);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire
